//--- design/decode_pkg.sv
`default_nettype none

package decode_pkg;

    typedef enum logic [7:0] {
        ALU_NOP = 8'h00,
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_NOR, ALU_AND, ALU_OR, ALU_XOR,
        ALU_ADDI, ALU_SLTI, ALU_SLTUI,
        ALU_ANDI, ALU_ORI, ALU_XORI,
        ALU_LD_W, ALU_ST_W,
        ALU_LU12I, ALU_PCADDU12I,
        ALU_JIRL, ALU_B, ALU_BL, ALU_BEQ, ALU_BNE,
        ALU_SYSCALL, ALU_BREAK
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP = 3'd0,
        SEL_ARITH,
        SEL_LOGIC,
        SEL_MEM,
        SEL_JUMP
    } alu_sel_e;

    typedef logic [6:0] exc_code_t;

    localparam exc_code_t EXC_NOP = 7'h00;
    localparam exc_code_t EXC_SYS = 7'h0B;
    localparam exc_code_t EXC_BRK = 7'h0C;
    localparam exc_code_t EXC_INE = 7'h0D;   // illegal instruction

    typedef struct packed {
        alu_op_e             aluop;
        alu_sel_e            alusel;
        isa_pkg::word_t      imm;
        logic                reg1_read_en;
        isa_pkg::reg_addr_t  reg1_read_addr;
        logic                reg2_read_en;
        isa_pkg::reg_addr_t  reg2_read_addr;
        logic                reg_write_en;
        isa_pkg::reg_addr_t  reg_write_addr;
    } uop_t;

    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t inst;
        logic           pre_taken;
        isa_pkg::word_t pre_addr;
        logic           pc_exc;
        exc_code_t      pc_cause;
        logic           ib_exc;          // instruction buffer side
        exc_code_t      ib_cause;
    } fetch_t;

    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t inst;
        uop_t           uop;
        logic [2:0]     is_exception;    // {pc, instbuffer, decoder}
        exc_code_t      pc_cause;
        exc_code_t      ib_cause;
        exc_code_t      dec_cause;
        logic           pre_taken;
        isa_pkg::word_t pre_addr;
    } id_out_t;

endpackage

`default_nettype wire

//--- design/id_fmt_1ri20.sv
`timescale 1ns/1ps
`default_nettype none

module id_fmt_1ri20 (
    input  isa_pkg::word_t   inst,
    output logic             hit,
    output decode_pkg::uop_t uop
);
    import isa_pkg::*;
    import decode_pkg::*;

    always_comb begin
        hit = 1'b1;
        uop = '0;
        case (op1ri20_e'(inst[31:25]))
            OP1RI20_LU12I_W:   uop.aluop = ALU_LU12I;
            OP1RI20_PCADDU12I: uop.aluop = ALU_PCADDU12I;
            default:           hit = 1'b0;
        endcase

        if (hit) begin
            uop.alusel         = SEL_ARITH;
            uop.imm            = {inst[24:5], 12'b0};   // upper 20 bits
            uop.reg_write_en   = 1'b1;
            uop.reg_write_addr = inst[RD_LSB +: $bits(reg_addr_t)];
        end
    end

endmodule

`default_nettype wire

//--- design/id_fmt_2ri12.sv
`timescale 1ns/1ps
`default_nettype none

module id_fmt_2ri12 (
    input  isa_pkg::word_t   inst,
    output logic             hit,
    output decode_pkg::uop_t uop
);
    import isa_pkg::*;
    import decode_pkg::*;

    always_comb begin
        hit = 1'b1;
        uop = '0;
        case (op2ri12_e'(inst[31:22]))
            OP2RI12_SLTI:   uop.aluop = ALU_SLTI;
            OP2RI12_SLTUI:  uop.aluop = ALU_SLTUI;
            OP2RI12_ADDI_W: uop.aluop = ALU_ADDI;
            OP2RI12_ANDI:   uop.aluop = ALU_ANDI;
            OP2RI12_ORI:    uop.aluop = ALU_ORI;
            OP2RI12_XORI:   uop.aluop = ALU_XORI;
            OP2RI12_LD_W:   uop.aluop = ALU_LD_W;
            OP2RI12_ST_W:   uop.aluop = ALU_ST_W;
            default:        hit = 1'b0;
        endcase

        if (hit) begin
            if (uop.aluop inside {ALU_LD_W, ALU_ST_W})
                uop.alusel = SEL_MEM;
            else if (uop.aluop inside {ALU_ANDI, ALU_ORI, ALU_XORI})
                uop.alusel = SEL_LOGIC;
            else
                uop.alusel = SEL_ARITH;

            // logical immediates are zero extended
            if (uop.alusel == SEL_LOGIC)
                uop.imm = {20'b0, inst[21:10]};
            else
                uop.imm = {{20{inst[21]}}, inst[21:10]};

            uop.reg1_read_en   = 1'b1;
            uop.reg1_read_addr = inst[RJ_LSB +: $bits(reg_addr_t)];
            if (uop.aluop == ALU_ST_W) begin
                uop.reg2_read_en   = 1'b1;   // store data from rd
                uop.reg2_read_addr = inst[RD_LSB +: $bits(reg_addr_t)];
            end else begin
                uop.reg_write_en   = 1'b1;
                uop.reg_write_addr = inst[RD_LSB +: $bits(reg_addr_t)];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/id_fmt_3r.sv
`timescale 1ns/1ps
`default_nettype none

module id_fmt_3r (
    input  isa_pkg::word_t   inst,
    output logic             hit,
    output decode_pkg::uop_t uop
);
    import isa_pkg::*;
    import decode_pkg::*;

    logic rr_op;   // reads rj, rk and writes rd

    always_comb begin
        hit   = 1'b1;
        rr_op = 1'b1;
        uop   = '0;
        case (op3r_e'(inst[31:15]))
            OP3R_ADD_W: uop.aluop = ALU_ADD;
            OP3R_SUB_W: uop.aluop = ALU_SUB;
            OP3R_SLT:   uop.aluop = ALU_SLT;
            OP3R_SLTU:  uop.aluop = ALU_SLTU;
            OP3R_NOR:   uop.aluop = ALU_NOR;
            OP3R_AND:   uop.aluop = ALU_AND;
            OP3R_OR:    uop.aluop = ALU_OR;
            OP3R_XOR:   uop.aluop = ALU_XOR;
            OP3R_SYSCALL: begin
                uop.aluop = ALU_SYSCALL;
                rr_op     = 1'b0;
            end
            OP3R_BREAK: begin
                uop.aluop = ALU_BREAK;
                rr_op     = 1'b0;
            end
            default: begin
                hit   = 1'b0;
                rr_op = 1'b0;
            end
        endcase

        if (rr_op) begin
            if (uop.aluop inside {ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU})
                uop.alusel = SEL_ARITH;
            else
                uop.alusel = SEL_LOGIC;
            uop.reg1_read_en   = 1'b1;
            uop.reg1_read_addr = inst[RJ_LSB +: $bits(reg_addr_t)];
            uop.reg2_read_en   = 1'b1;
            uop.reg2_read_addr = inst[RK_LSB +: $bits(reg_addr_t)];
            uop.reg_write_en   = 1'b1;
            uop.reg_write_addr = inst[RD_LSB +: $bits(reg_addr_t)];
        end
    end

endmodule

`default_nettype wire

//--- design/id_fmt_branch.sv
`timescale 1ns/1ps
`default_nettype none

module id_fmt_branch (
    input  isa_pkg::word_t   inst,
    output logic             hit,
    output decode_pkg::uop_t uop
);
    import isa_pkg::*;
    import decode_pkg::*;

    word_t imm16;   // jirl, beq, bne
    word_t imm26;   // b, bl

    assign imm16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign imm26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        hit = 1'b1;
        uop = '0;
        case (opbr_e'(inst[31:26]))
            OPBR_JIRL: uop.aluop = ALU_JIRL;
            OPBR_B:    uop.aluop = ALU_B;
            OPBR_BL:   uop.aluop = ALU_BL;
            OPBR_BEQ:  uop.aluop = ALU_BEQ;
            OPBR_BNE:  uop.aluop = ALU_BNE;
            default:   hit = 1'b0;
        endcase

        if (hit) begin
            uop.alusel = SEL_JUMP;
            uop.imm    = (uop.aluop inside {ALU_B, ALU_BL}) ? imm26 : imm16;
            if (uop.aluop inside {ALU_JIRL, ALU_BEQ, ALU_BNE}) begin
                uop.reg1_read_en   = 1'b1;
                uop.reg1_read_addr = inst[RJ_LSB +: $bits(reg_addr_t)];
            end
            if (uop.aluop inside {ALU_BEQ, ALU_BNE}) begin
                uop.reg2_read_en   = 1'b1;   // compare against rd
                uop.reg2_read_addr = inst[RD_LSB +: $bits(reg_addr_t)];
            end
            if (uop.aluop == ALU_JIRL) begin
                uop.reg_write_en   = 1'b1;
                uop.reg_write_addr = inst[RD_LSB +: $bits(reg_addr_t)];
            end else if (uop.aluop == ALU_BL) begin
                uop.reg_write_en   = 1'b1;
                uop.reg_write_addr = reg_addr_t'(1);   // link register r1
            end
        end
    end

endmodule

`default_nettype wire

//--- design/id_select.sv
`timescale 1ns/1ps
`default_nettype none

module id_select (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid,
    input  decode_pkg::fetch_t  fetch,
    input  logic [3:0]          hit,
    input  decode_pkg::uop_t    uops [4],
    output logic                id_valid,
    output decode_pkg::id_out_t id_out
);
    import decode_pkg::*;

    uop_t      sel_uop;
    logic      any_hit;
    logic      dec_exc;
    exc_code_t dec_cause;
    id_out_t   nxt;

    assign any_hit = |hit;

    always_comb begin
        sel_uop = '0;
        for (int i = 0; i < 4; i++) begin
            if (hit[i])
                sel_uop = uops[i];
        end
    end

    always_comb begin
        dec_exc   = 1'b1;
        dec_cause = EXC_INE;   // nothing matched
        if (any_hit) begin
            dec_exc = sel_uop.aluop inside {ALU_SYSCALL, ALU_BREAK};
            if (sel_uop.aluop == ALU_SYSCALL)
                dec_cause = EXC_SYS;
            else if (sel_uop.aluop == ALU_BREAK)
                dec_cause = EXC_BRK;
            else
                dec_cause = EXC_NOP;
        end
    end

    always_comb begin
        nxt.pc           = fetch.pc;
        nxt.inst         = any_hit ? fetch.inst : '0;
        nxt.uop          = sel_uop;
        nxt.is_exception = {fetch.pc_exc, fetch.ib_exc, dec_exc};
        nxt.pc_cause     = fetch.pc_cause;
        nxt.ib_cause     = fetch.ib_cause;
        nxt.dec_cause    = dec_cause;
        nxt.pre_taken    = fetch.pre_taken;
        nxt.pre_addr     = fetch.pre_addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
            id_out   <= '0;
        end else begin
            id_valid <= valid;
            if (valid)
                id_out <= nxt;   // holds while idle
        end
    end

    // format opcodes are disjoint across the four decoders
    assert property (@(posedge clk) disable iff (rst) valid |-> $onehot0(hit))
        else $error("id_select: more than one format decoder hit");

    assert property (@(posedge clk) disable iff (rst)
        id_out.is_exception[0] |-> id_out.dec_cause != EXC_NOP)
        else $error("id_select: decoder exception flagged without a cause");

endmodule

`default_nettype wire

//--- design/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid,
    input  decode_pkg::fetch_t  fetch,
    output logic                id_valid,
    output decode_pkg::id_out_t id_out
);
    import decode_pkg::*;

    logic [3:0] hit;    // one bit per format decoder
    uop_t       uops [4];

    id_fmt_3r i_fmt_3r (
        .inst (fetch.inst),
        .hit  (hit[0]),
        .uop  (uops[0])
    );

    id_fmt_2ri12 i_fmt_2ri12 (
        .inst (fetch.inst),
        .hit  (hit[1]),
        .uop  (uops[1])
    );

    id_fmt_1ri20 i_fmt_1ri20 (
        .inst (fetch.inst),
        .hit  (hit[2]),
        .uop  (uops[2])
    );

    id_fmt_branch i_fmt_branch (
        .inst (fetch.inst),
        .hit  (hit[3]),
        .uop  (uops[3])
    );

    id_select i_select (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .fetch    (fetch),
        .hit      (hit),
        .uops     (uops),
        .id_valid (id_valid),
        .id_out   (id_out)
    );

endmodule

`default_nettype wire

//--- design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;      // data, instruction or address
    typedef logic [4:0]  reg_addr_t;

    // register field positions
    localparam int RD_LSB = 0;
    localparam int RJ_LSB = 5;
    localparam int RK_LSB = 10;

    typedef enum logic [16:0] {       // inst[31:15]
        OP3R_ADD_W   = 17'h00020,
        OP3R_SUB_W   = 17'h00022,
        OP3R_SLT     = 17'h00024,
        OP3R_SLTU    = 17'h00025,
        OP3R_NOR     = 17'h00028,
        OP3R_AND     = 17'h00029,
        OP3R_OR      = 17'h0002A,
        OP3R_XOR     = 17'h0002B,
        OP3R_BREAK   = 17'h00054,
        OP3R_SYSCALL = 17'h00056
    } op3r_e;

    typedef enum logic [9:0] {        // inst[31:22]
        OP2RI12_SLTI   = 10'h008,
        OP2RI12_SLTUI  = 10'h009,
        OP2RI12_ADDI_W = 10'h00A,
        OP2RI12_ANDI   = 10'h00D,
        OP2RI12_ORI    = 10'h00E,
        OP2RI12_XORI   = 10'h00F,
        OP2RI12_LD_W   = 10'h0A2,
        OP2RI12_ST_W   = 10'h0A6
    } op2ri12_e;

    typedef enum logic [6:0] {        // inst[31:25]
        OP1RI20_LU12I_W   = 7'h0A,
        OP1RI20_PCADDU12I = 7'h0E
    } op1ri20_e;

    typedef enum logic [5:0] {        // inst[31:26]
        OPBR_JIRL = 6'h13,
        OPBR_B    = 6'h14,
        OPBR_BL   = 6'h15,
        OPBR_BEQ  = 6'h16,
        OPBR_BNE  = 6'h17
    } opbr_e;

endpackage

`default_nettype wire

//--- tests/id_checker.sv
`timescale 1ns/1ps
`default_nettype none

module id_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid,
    input  decode_pkg::fetch_t  fetch,
    input  logic                id_valid,
    input  decode_pkg::id_out_t id_out,
    output int                  checks,
    output int                  errors,
    output int                  pending
);
    import isa_pkg::*;
    import decode_pkg::*;

    id_out_t exp_q [$];     // one entry per accepted instruction
    id_out_t last_exp = '0; // what id_out holds while idle
    logic    rst_q   = 1'b1;
    logic    valid_q = 1'b0;

    initial begin
        checks  = 0;
        errors  = 0;
        pending = 0;
    end

    function automatic id_out_t ref_decode(input fetch_t f);
        id_out_t     e;
        uop_t        u;
        word_t       i;
        alu_op_e     op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [15:0] off16;
        logic [25:0] off26;
        i     = f.inst;
        rd    = i[4:0];
        rj    = i[9:5];
        rk    = i[14:10];
        off16 = i[25:10];
        off26 = {i[9:0], i[25:10]};
        op    = ALU_NOP;     // stays nop when no format matches
        case (i[31:15])
            OP3R_ADD_W:   op = ALU_ADD;
            OP3R_SUB_W:   op = ALU_SUB;
            OP3R_SLT:     op = ALU_SLT;
            OP3R_SLTU:    op = ALU_SLTU;
            OP3R_NOR:     op = ALU_NOR;
            OP3R_AND:     op = ALU_AND;
            OP3R_OR:      op = ALU_OR;
            OP3R_XOR:     op = ALU_XOR;
            OP3R_SYSCALL: op = ALU_SYSCALL;
            OP3R_BREAK:   op = ALU_BREAK;
            default:      ;
        endcase
        case (i[31:22])
            OP2RI12_SLTI:   op = ALU_SLTI;
            OP2RI12_SLTUI:  op = ALU_SLTUI;
            OP2RI12_ADDI_W: op = ALU_ADDI;
            OP2RI12_ANDI:   op = ALU_ANDI;
            OP2RI12_ORI:    op = ALU_ORI;
            OP2RI12_XORI:   op = ALU_XORI;
            OP2RI12_LD_W:   op = ALU_LD_W;
            OP2RI12_ST_W:   op = ALU_ST_W;
            default:        ;
        endcase
        case (i[31:25])
            OP1RI20_LU12I_W:   op = ALU_LU12I;
            OP1RI20_PCADDU12I: op = ALU_PCADDU12I;
            default:           ;
        endcase
        case (i[31:26])
            OPBR_JIRL: op = ALU_JIRL;
            OPBR_B:    op = ALU_B;
            OPBR_BL:   op = ALU_BL;
            OPBR_BEQ:  op = ALU_BEQ;
            OPBR_BNE:  op = ALU_BNE;
            default:   ;
        endcase

        u       = '0;
        u.aluop = op;
        if (op inside {ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND, ALU_OR, ALU_XOR})
        begin
            if (op inside {ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU})
                u.alusel = SEL_ARITH;
            else
                u.alusel = SEL_LOGIC;
            u.reg1_read_en   = 1'b1;
            u.reg1_read_addr = rj;
            u.reg2_read_en   = 1'b1;
            u.reg2_read_addr = rk;
            u.reg_write_en   = 1'b1;
            u.reg_write_addr = rd;
        end
        if (op inside {ALU_SLTI, ALU_SLTUI, ALU_ADDI, ALU_ANDI, ALU_ORI, ALU_XORI,
                       ALU_LD_W, ALU_ST_W}) begin
            u.reg1_read_en   = 1'b1;
            u.reg1_read_addr = rj;
            if (op inside {ALU_ANDI, ALU_ORI, ALU_XORI}) begin
                u.alusel = SEL_LOGIC;
                u.imm    = word_t'(i[21:10]);    // zero extended
            end else begin
                u.imm = word_t'($signed(i[21:10]));
                if (op inside {ALU_LD_W, ALU_ST_W})
                    u.alusel = SEL_MEM;
                else
                    u.alusel = SEL_ARITH;
            end
            if (op == ALU_ST_W) begin
                u.reg2_read_en   = 1'b1;
                u.reg2_read_addr = rd;
            end else begin
                u.reg_write_en   = 1'b1;
                u.reg_write_addr = rd;
            end
        end
        if (op inside {ALU_LU12I, ALU_PCADDU12I}) begin
            u.alusel         = SEL_ARITH;
            u.imm            = {i[24:5], 12'h000};
            u.reg_write_en   = 1'b1;
            u.reg_write_addr = rd;
        end
        if (op inside {ALU_JIRL, ALU_B, ALU_BL, ALU_BEQ, ALU_BNE}) begin
            u.alusel = SEL_JUMP;
            if (op inside {ALU_B, ALU_BL})
                u.imm = word_t'($signed(off26)) << 2;
            else
                u.imm = word_t'($signed(off16)) << 2;
            if (op inside {ALU_JIRL, ALU_BEQ, ALU_BNE}) begin
                u.reg1_read_en   = 1'b1;
                u.reg1_read_addr = rj;
            end
            if (op inside {ALU_BEQ, ALU_BNE}) begin
                u.reg2_read_en   = 1'b1;
                u.reg2_read_addr = rd;
            end
            if (op == ALU_JIRL) begin
                u.reg_write_en   = 1'b1;
                u.reg_write_addr = rd;
            end
            if (op == ALU_BL) begin
                u.reg_write_en   = 1'b1;
                u.reg_write_addr = 5'd1;    // link register
            end
        end

        e              = '0;
        e.pc           = f.pc;
        e.inst         = (op == ALU_NOP) ? 32'h0 : i;
        e.uop          = u;
        e.is_exception = {f.pc_exc, f.ib_exc, op inside {ALU_NOP, ALU_SYSCALL, ALU_BREAK}};
        e.pc_cause     = f.pc_cause;
        e.ib_cause     = f.ib_cause;
        if (op == ALU_NOP)
            e.dec_cause = EXC_INE;
        else if (op == ALU_SYSCALL)
            e.dec_cause = EXC_SYS;
        else if (op == ALU_BREAK)
            e.dec_cause = EXC_BRK;
        else
            e.dec_cause = EXC_NOP;
        e.pre_taken = f.pre_taken;
        e.pre_addr  = f.pre_addr;
        return e;
    endfunction

    task automatic check_field(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic compare(input id_out_t exp, input id_out_t act);
        check_field("id_out.pc", exp.pc, act.pc);
        check_field("id_out.inst", exp.inst, act.inst);
        check_field("id_out.uop.aluop", exp.uop.aluop, act.uop.aluop);
        check_field("id_out.uop.alusel", exp.uop.alusel, act.uop.alusel);
        check_field("id_out.uop.imm", exp.uop.imm, act.uop.imm);
        check_field("id_out.uop.reg1_read_en", exp.uop.reg1_read_en, act.uop.reg1_read_en);
        check_field("id_out.uop.reg1_read_addr", exp.uop.reg1_read_addr,
                    act.uop.reg1_read_addr);
        check_field("id_out.uop.reg2_read_en", exp.uop.reg2_read_en, act.uop.reg2_read_en);
        check_field("id_out.uop.reg2_read_addr", exp.uop.reg2_read_addr,
                    act.uop.reg2_read_addr);
        check_field("id_out.uop.reg_write_en", exp.uop.reg_write_en, act.uop.reg_write_en);
        check_field("id_out.uop.reg_write_addr", exp.uop.reg_write_addr,
                    act.uop.reg_write_addr);
        check_field("id_out.is_exception", exp.is_exception, act.is_exception);
        check_field("id_out.pc_cause", exp.pc_cause, act.pc_cause);
        check_field("id_out.ib_cause", exp.ib_cause, act.ib_cause);
        check_field("id_out.dec_cause", exp.dec_cause, act.dec_cause);
        check_field("id_out.pre_taken", exp.pre_taken, act.pre_taken);
        check_field("id_out.pre_addr", exp.pre_addr, act.pre_addr);
    endtask

    always @(posedge clk) begin
        if (!rst && rst_q) begin    // first edge after reset released
            check_field("id_valid", 64'h0, id_valid);
            compare(id_out_t'('0), id_out);
        end else if (!rst) begin
            check_field("id_valid", valid_q, id_valid);
            if (id_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("id_valid went high with no instruction outstanding");
                end else begin
                    last_exp = exp_q.pop_front();
                    compare(last_exp, id_out);
                    checks++;
                end
            end else begin
                compare(last_exp, id_out);    // idle output keeps the last result
            end
        end
        if (rst) begin
            exp_q.delete();
            last_exp = '0;
        end else if (valid) begin
            exp_q.push_back(ref_decode(fetch));
        end
        pending = exp_q.size();
        rst_q   <= rst;
        valid_q <= valid;
    end

endmodule

`default_nettype wire

//--- tests/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
    import isa_pkg::*;
    import decode_pkg::*;

    localparam int N_TEST       = 200;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN        = 3;
    // five tests of up to N_TEST cycles each, two resets, plus margin
    localparam int MAX_CYCLES = 2 * RESET_CYCLES + 1 + 5 * (N_TEST + DRAIN) + 100;

    logic    clk;
    logic    rst;
    logic    valid;
    fetch_t  fetch;
    logic    id_valid;
    id_out_t id_out;

    int          checks;
    int          errors;
    int          pending;
    int          tb_errors   = 0;
    int          mark_checks = 0;
    int          mark_errors = 0;
    int          cycles      = 0;
    logic [31:0] rng_state   = 32'd88;

    op3r_e alu_3r [8] = '{OP3R_ADD_W, OP3R_SUB_W, OP3R_SLT, OP3R_SLTU,
                          OP3R_NOR, OP3R_AND, OP3R_OR, OP3R_XOR};
    op2ri12_e imm_ops [8] = '{OP2RI12_SLTI, OP2RI12_SLTUI, OP2RI12_ADDI_W, OP2RI12_ANDI,
                              OP2RI12_ORI, OP2RI12_XORI, OP2RI12_LD_W, OP2RI12_ST_W};
    op1ri20_e upper_ops [2] = '{OP1RI20_LU12I_W, OP1RI20_PCADDU12I};
    opbr_e    br_ops [5]    = '{OPBR_JIRL, OPBR_B, OPBR_BL, OPBR_BEQ, OPBR_BNE};

    id_stage i_id_stage (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .fetch    (fetch),
        .id_valid (id_valid),
        .id_out   (id_out)
    );

    id_checker i_checker (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .fetch    (fetch),
        .id_valid (id_valid),
        .id_out   (id_out),
        .checks   (checks),
        .errors   (errors),
        .pending  (pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // kind 0 is 3r alu, 1 2ri12, 2 1ri20, 3 branch, 4 syscall/break, else random word
    function automatic word_t make_inst(input int kind);
        logic [31:0] r;
        logic [31:0] s;
        r = next_rand();
        s = next_rand();
        case (kind)
            0:       return {alu_3r[s[2:0]], r[14:0]};
            1:       return {imm_ops[s[2:0]], r[21:0]};
            2:       return {upper_ops[s[0]], r[24:0]};
            3:       return {br_ops[s % 5], r[25:0]};
            4:       return {s[0] ? OP3R_SYSCALL : OP3R_BREAK, r[14:0]};
            default: return r;
        endcase
    endfunction

    task automatic send(input word_t inst);
        fetch_t      f;
        logic [31:0] r;
        r           = next_rand();
        f.pc        = next_rand();
        f.inst      = inst;
        f.pre_taken = r[0];
        f.pre_addr  = next_rand();
        f.pc_exc    = r[1];
        f.pc_cause  = r[8:2];
        f.ib_exc    = r[9];
        f.ib_cause  = r[16:10];
        @(posedge clk);
        valid <= 1'b1;
        fetch <= f;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            valid <= 1'b0;
        end
    endtask

    task automatic end_test(input string name);
        int c;
        int e;
        idle(DRAIN);
        @(negedge clk);    // counters settle after the checker's edge
        if (pending != 0) begin
            tb_errors++;
            $display("%s: %0d results never appeared on id_out", name, pending);
        end
        c = checks - mark_checks;
        e = errors + tb_errors - mark_errors;
        $display("%-13s %4d checks, %0d errors", name, c, e);
        mark_checks = checks;
        mark_errors = errors + tb_errors;
    endtask

    initial begin
        logic [31:0] r;
        int          total;
        rst   = 1'b1;
        valid = 1'b0;
        fetch = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int n = 0; n < N_TEST; n++)
            send(make_inst(0));
        end_test("3r_alu");

        for (int n = 0; n < N_TEST; n++)
            send(make_inst(1));
        end_test("2ri12");

        for (int n = 0; n < N_TEST; n++) begin
            r = next_rand();
            send(make_inst(r[0] ? 3 : 2));
        end
        end_test("upper_branch");

        for (int n = 0; n < N_TEST; n++) begin
            r = next_rand();
            send(make_inst(r[0] ? 4 : 5));
        end
        end_test("exceptions");

        for (int n = 0; n < N_TEST; n++) begin
            if (n == N_TEST / 2) begin    // reset in the middle of traffic
                @(posedge clk);
                rst   <= 1'b1;
                valid <= 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                rst <= 1'b0;
            end
            r = next_rand();
            if (r[1:0] == 2'b00)
                idle(1);
            else
                send(make_inst(r[4:2] % 6));
        end
        end_test("gaps_reset");

        total = errors + tb_errors;
        $display("total: %0d checks, %0d errors", checks, total);
        if (total == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
design/isa_pkg.sv
design/decode_pkg.sv
design/id_fmt_3r.sv
design/id_fmt_2ri12.sv
design/id_fmt_1ri20.sv
design/id_fmt_branch.sv
design/id_select.sv
design/id_stage.sv
tests/id_checker.sv
tests/tb_id_stage.sv
